// File: src/noc_pkg.sv
package noc_pkg;

  localparam int flit_width_lp   = 32;
  localparam int x_dim_lp        = 2;
  localparam int y_dim_lp        = 2;
  localparam int num_tile_lp     = x_dim_lp * y_dim_lp;  // tile index is y*2+x.
  localparam int io_x_lp         = 2;                    // east of router (1,0).
  localparam int cord_x_width_lp = 2;
  localparam int cord_y_width_lp = 1;
  localparam int len_width_lp    = 3;

  // router ports, N is toward y-1.
  localparam int dir_p_lp   = 0;
  localparam int dir_w_lp   = 1;
  localparam int dir_e_lp   = 2;
  localparam int dir_n_lp   = 3;
  localparam int dir_s_lp   = 4;
  localparam int num_dir_lp = 5;

  // header or body, decided by the packet state of the input.
  typedef union packed {
    struct packed {
      logic [cord_x_width_lp-1:0] dest_x;
      logic [cord_y_width_lp-1:0] dest_y;
      logic [len_width_lp-1:0]    len;
      logic [cord_x_width_lp-1:0] src_x;
      logic [cord_y_width_lp-1:0] src_y;
      logic [flit_width_lp-2*(cord_x_width_lp+cord_y_width_lp)-len_width_lp-1:0] payload;
    } hdr;
    logic [flit_width_lp-1:0] data;
  } flit_u;

endpackage

// File: src/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo
  (input  logic           clk_i
  ,input  logic           rst_n_i
  ,input  logic           v_i
  ,input  noc_pkg::flit_u flit_i
  ,output logic           ready_and_o
  ,output logic           v_o
  ,output noc_pkg::flit_u flit_o
  ,input  logic           yumi_i
  );

  import noc_pkg::*;

  flit_u      mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;

  assign ready_and_o = (count_r != 2'd2);  // only buffer space.
  assign v_o         = (count_r != 2'd0);
  assign flit_o      = mem_r[rd_ptr_r];
  assign push        = v_i & ready_and_o;

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= flit_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, yumi_i};
    end
  end

  // the router only pops a flit it has seen.
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule

// File: src/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter
  (input  logic                           clk_i
  ,input  logic                           rst_n_i
  ,input  logic [noc_pkg::num_dir_lp-1:0] req_i
  ,input  logic                           hold_i
  ,input  logic                           done_i
  ,output logic [noc_pkg::num_dir_lp-1:0] grant_o
  );

  import noc_pkg::*;

  logic [num_dir_lp-1:0] last_r;  // one-hot last winner.
  logic [num_dir_lp-1:0] held_r;
  logic [num_dir_lp-1:0] pick;

  // search starts just after the last winner.
  always_comb
  begin
    int start;
    start = 0;
    for (int k = 0; k < num_dir_lp; k++)
      if (last_r[k])
        start = k + 1;
    pick = '0;
    for (int k = num_dir_lp - 1; k >= 0; k--)
      if (req_i[(start + k) % num_dir_lp])
      begin
        pick = '0;
        pick[(start + k) % num_dir_lp] = 1'b1;
      end
  end

  assign grant_o = hold_i ? held_r : pick;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      last_r <= '0;
      held_r <= '0;
    end
    else
    begin
      if (!hold_i)
        held_r <= pick;
      if (done_i)
        last_r <= grant_o;  // rotate on tail only.
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_o));

endmodule

// File: src/wormhole_router.sv
`timescale 1ns/1ps

module wormhole_router
  #(parameter int my_x_p = 0
   ,parameter int my_y_p = 0
   )
  (input  logic                                      clk_i
  ,input  logic                                      rst_n_i
  ,input  logic           [noc_pkg::num_dir_lp-1:0]  link_v_i
  ,input  noc_pkg::flit_u [noc_pkg::num_dir_lp-1:0]  link_flit_i
  ,output logic           [noc_pkg::num_dir_lp-1:0]  link_ready_and_o
  ,output logic           [noc_pkg::num_dir_lp-1:0]  link_v_o
  ,output noc_pkg::flit_u [noc_pkg::num_dir_lp-1:0]  link_flit_o
  ,input  logic           [noc_pkg::num_dir_lp-1:0]  link_ready_and_i
  );

  import noc_pkg::*;

  logic  [num_dir_lp-1:0]                   fifo_v;
  flit_u [num_dir_lp-1:0]                   fifo_flit;
  logic  [num_dir_lp-1:0]                   fifo_yumi;
  logic  [num_dir_lp-1:0]                   hdr_r;    // next flit is a header.
  logic  [num_dir_lp-1:0]                   last;     // head flit ends its packet.
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   route;    // [in][out]
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   dir_r;    // [in][out]
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   cur_dir;  // [in][out]
  logic  [num_dir_lp-1:0][len_width_lp-1:0] cnt_r;
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   req;      // [out][in]
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   grant;    // [out][in]
  logic  [num_dir_lp-1:0][num_dir_lp-1:0]   send;     // [out][in]
  logic  [num_dir_lp-1:0]                   lock_r;
  logic  [num_dir_lp-1:0]                   out_go;
  logic  [num_dir_lp-1:0]                   done;

  // Y first, then X.
  function automatic logic [num_dir_lp-1:0] route_f(flit_u f);
    logic [num_dir_lp-1:0] oh;
    oh = '0;
    if (f.hdr.dest_y > my_y_p)
      oh[dir_s_lp] = 1'b1;
    else if (f.hdr.dest_y < my_y_p)
      oh[dir_n_lp] = 1'b1;
    else if (f.hdr.dest_x > my_x_p)
      oh[dir_e_lp] = 1'b1;
    else if (f.hdr.dest_x < my_x_p)
      oh[dir_w_lp] = 1'b1;
    else
      oh[dir_p_lp] = 1'b1;
    return oh;
  endfunction

  // ********************************************************************
  // input side
  // ********************************************************************

  for (genvar i = 0; i < num_dir_lp; i++)
  begin : in_g
    flit_fifo u_fifo
      (.clk_i       (clk_i)
      ,.rst_n_i     (rst_n_i)
      ,.v_i         (link_v_i[i])
      ,.flit_i      (link_flit_i[i])
      ,.ready_and_o (link_ready_and_o[i])
      ,.v_o         (fifo_v[i])
      ,.flit_o      (fifo_flit[i])
      ,.yumi_i      (fifo_yumi[i])
      );

    a_edge_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fifo_v[i] && hdr_r[i]) |->
        !((my_x_p == 0 && route[i][dir_w_lp])
          || (my_y_p == 0 && route[i][dir_n_lp])
          || (my_y_p == y_dim_lp - 1 && route[i][dir_s_lp])));

    // a body flit always trails a header that still holds its output.
    a_body_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fifo_v[i] && !hdr_r[i]) |-> |(dir_r[i] & lock_r));
  end

  always_comb
  begin
    for (int i = 0; i < num_dir_lp; i++)
    begin
      route[i]   = route_f(fifo_flit[i]);
      cur_dir[i] = hdr_r[i] ? route[i] : dir_r[i];
      last[i]    = hdr_r[i] ? (fifo_flit[i].hdr.len == '0)
                            : (cnt_r[i] == len_width_lp'(1));
    end
    for (int o = 0; o < num_dir_lp; o++)
      for (int i = 0; i < num_dir_lp; i++)
        req[o][i] = fifo_v[i] & cur_dir[i][o];
  end

  // ********************************************************************
  // output side
  // ********************************************************************

  for (genvar o = 0; o < num_dir_lp; o++)
  begin : out_g
    rr_arbiter u_arb
      (.clk_i   (clk_i)
      ,.rst_n_i (rst_n_i)
      ,.req_i   (req[o])
      ,.hold_i  (lock_r[o])
      ,.done_i  (done[o])
      ,.grant_o (grant[o])
      );

    a_one_sender: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(send[o]));
  end

  always_comb
  begin
    fifo_yumi   = '0;
    link_flit_o = '0;
    for (int o = 0; o < num_dir_lp; o++)
    begin
      send[o]     = grant[o] & req[o];
      link_v_o[o] = |send[o];
      out_go[o]   = link_v_o[o] & link_ready_and_i[o];
      done[o]     = out_go[o] & |(send[o] & last);
      for (int i = 0; i < num_dir_lp; i++)
        if (grant[o][i])
          link_flit_o[o] = fifo_flit[i];
      fifo_yumi = fifo_yumi | (send[o] & {num_dir_lp{out_go[o]}});
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hdr_r  <= '1;
      dir_r  <= '0;
      cnt_r  <= '0;
      lock_r <= '0;
    end
    else
    begin
      for (int i = 0; i < num_dir_lp; i++)
        if (fifo_yumi[i])
        begin
          hdr_r[i] <= last[i];
          if (hdr_r[i])
          begin
            dir_r[i] <= route[i];             // kept for the body.
            cnt_r[i] <= fifo_flit[i].hdr.len;
          end
          else
            cnt_r[i] <= cnt_r[i] - 1'b1;
        end
      for (int o = 0; o < num_dir_lp; o++)
        if (out_go[o])
          lock_r[o] <= ~done[o];  // held until the tail leaves.
    end
  end

endmodule

// File: src/io_complex.sv
`timescale 1ns/1ps

module io_complex
  (input  logic                                      clk_i
  ,input  logic                                      rst_n_i

  ,input  logic           [noc_pkg::num_tile_lp-1:0] cmd_tile_v_i
  ,input  noc_pkg::flit_u [noc_pkg::num_tile_lp-1:0] cmd_tile_flit_i
  ,output logic           [noc_pkg::num_tile_lp-1:0] cmd_tile_ready_and_o
  ,output logic           [noc_pkg::num_tile_lp-1:0] cmd_tile_v_o
  ,output noc_pkg::flit_u [noc_pkg::num_tile_lp-1:0] cmd_tile_flit_o
  ,input  logic           [noc_pkg::num_tile_lp-1:0] cmd_tile_ready_and_i
  ,input  logic                                      cmd_io_v_i
  ,input  noc_pkg::flit_u                            cmd_io_flit_i
  ,output logic                                      cmd_io_ready_and_o
  ,output logic                                      cmd_io_v_o
  ,output noc_pkg::flit_u                            cmd_io_flit_o
  ,input  logic                                      cmd_io_ready_and_i

  ,input  logic           [noc_pkg::num_tile_lp-1:0] resp_tile_v_i
  ,input  noc_pkg::flit_u [noc_pkg::num_tile_lp-1:0] resp_tile_flit_i
  ,output logic           [noc_pkg::num_tile_lp-1:0] resp_tile_ready_and_o
  ,output logic           [noc_pkg::num_tile_lp-1:0] resp_tile_v_o
  ,output noc_pkg::flit_u [noc_pkg::num_tile_lp-1:0] resp_tile_flit_o
  ,input  logic           [noc_pkg::num_tile_lp-1:0] resp_tile_ready_and_i
  ,input  logic                                      resp_io_v_i
  ,input  noc_pkg::flit_u                            resp_io_flit_i
  ,output logic                                      resp_io_ready_and_o
  ,output logic                                      resp_io_v_o
  ,output noc_pkg::flit_u                            resp_io_flit_o
  ,input  logic                                      resp_io_ready_and_i
  );

  import noc_pkg::*;

  // index [0] is the command network, [1] the response network.
  logic  [1:0][num_tile_lp-1:0] tile_v_li, tile_rdy_lo, tile_v_lo, tile_rdy_li;
  flit_u [1:0][num_tile_lp-1:0] tile_flit_li, tile_flit_lo;
  logic  [1:0]                  io_v_li, io_rdy_lo, io_v_lo, io_rdy_li;
  flit_u [1:0]                  io_flit_li, io_flit_lo;

  // router side of every link.
  logic  [1:0][y_dim_lp-1:0][x_dim_lp-1:0][num_dir_lp-1:0] in_v, in_rdy, out_v, out_rdy;
  flit_u [1:0][y_dim_lp-1:0][x_dim_lp-1:0][num_dir_lp-1:0] in_flit, out_flit;

  assign tile_v_li    = {resp_tile_v_i, cmd_tile_v_i};
  assign tile_flit_li = {resp_tile_flit_i, cmd_tile_flit_i};
  assign tile_rdy_li  = {resp_tile_ready_and_i, cmd_tile_ready_and_i};
  assign io_v_li      = {resp_io_v_i, cmd_io_v_i};
  assign io_flit_li   = {resp_io_flit_i, cmd_io_flit_i};
  assign io_rdy_li    = {resp_io_ready_and_i, cmd_io_ready_and_i};

  assign cmd_tile_ready_and_o  = tile_rdy_lo[0];
  assign cmd_tile_v_o          = tile_v_lo[0];
  assign cmd_tile_flit_o       = tile_flit_lo[0];
  assign cmd_io_ready_and_o    = io_rdy_lo[0];
  assign cmd_io_v_o            = io_v_lo[0];
  assign cmd_io_flit_o         = io_flit_lo[0];
  assign resp_tile_ready_and_o = tile_rdy_lo[1];
  assign resp_tile_v_o         = tile_v_lo[1];
  assign resp_tile_flit_o      = tile_flit_lo[1];
  assign resp_io_ready_and_o   = io_rdy_lo[1];
  assign resp_io_v_o           = io_v_lo[1];
  assign resp_io_flit_o        = io_flit_lo[1];

  // ********************************************************************
  // meshes and stitching
  // ********************************************************************

  for (genvar y = 0; y < y_dim_lp; y++)
  begin : y_g
    for (genvar x = 0; x < x_dim_lp; x++)
    begin : x_g
      for (genvar n = 0; n < 2; n++)
      begin : net_g
        wormhole_router
          #(.my_x_p (x)
           ,.my_y_p (y)
           )
          u_router
          (.clk_i            (clk_i)
          ,.rst_n_i          (rst_n_i)
          ,.link_v_i         (in_v[n][y][x])
          ,.link_flit_i      (in_flit[n][y][x])
          ,.link_ready_and_o (in_rdy[n][y][x])
          ,.link_v_o         (out_v[n][y][x])
          ,.link_flit_o      (out_flit[n][y][x])
          ,.link_ready_and_i (out_rdy[n][y][x])
          );

        // local tile port.
        assign in_v[n][y][x][dir_p_lp]           = tile_v_li[n][y*x_dim_lp+x];
        assign in_flit[n][y][x][dir_p_lp]        = tile_flit_li[n][y*x_dim_lp+x];
        assign out_rdy[n][y][x][dir_p_lp]        = tile_rdy_li[n][y*x_dim_lp+x];
        assign tile_rdy_lo[n][y*x_dim_lp+x]      = in_rdy[n][y][x][dir_p_lp];
        assign tile_v_lo[n][y*x_dim_lp+x]        = out_v[n][y][x][dir_p_lp];
        assign tile_flit_lo[n][y*x_dim_lp+x]     = out_flit[n][y][x][dir_p_lp];

        if (x > 0)
        begin : w_link
          assign in_v[n][y][x][dir_w_lp]    = out_v[n][y][x-1][dir_e_lp];
          assign in_flit[n][y][x][dir_w_lp] = out_flit[n][y][x-1][dir_e_lp];
          assign out_rdy[n][y][x][dir_w_lp] = in_rdy[n][y][x-1][dir_e_lp];
        end
        else
        begin : w_edge
          assign in_v[n][y][x][dir_w_lp]    = 1'b0;
          assign in_flit[n][y][x][dir_w_lp] = '0;
          assign out_rdy[n][y][x][dir_w_lp] = 1'b1;
        end

        if (x < x_dim_lp - 1)
        begin : e_link
          assign in_v[n][y][x][dir_e_lp]    = out_v[n][y][x+1][dir_w_lp];
          assign in_flit[n][y][x][dir_e_lp] = out_flit[n][y][x+1][dir_w_lp];
          assign out_rdy[n][y][x][dir_e_lp] = in_rdy[n][y][x+1][dir_w_lp];
        end
        else if (y == 0)
        begin : e_io
          assign in_v[n][y][x][dir_e_lp]    = io_v_li[n];
          assign in_flit[n][y][x][dir_e_lp] = io_flit_li[n];
          assign out_rdy[n][y][x][dir_e_lp] = io_rdy_li[n];
          assign io_rdy_lo[n]               = in_rdy[n][y][x][dir_e_lp];
          assign io_v_lo[n]                 = out_v[n][y][x][dir_e_lp];
          assign io_flit_lo[n]              = out_flit[n][y][x][dir_e_lp];
        end
        else
        begin : e_edge
          assign in_v[n][y][x][dir_e_lp]    = 1'b0;
          assign in_flit[n][y][x][dir_e_lp] = '0;
          assign out_rdy[n][y][x][dir_e_lp] = 1'b1;
        end

        if (y > 0)
        begin : n_link
          assign in_v[n][y][x][dir_n_lp]    = out_v[n][y-1][x][dir_s_lp];
          assign in_flit[n][y][x][dir_n_lp] = out_flit[n][y-1][x][dir_s_lp];
          assign out_rdy[n][y][x][dir_n_lp] = in_rdy[n][y-1][x][dir_s_lp];
        end
        else
        begin : n_edge
          assign in_v[n][y][x][dir_n_lp]    = 1'b0;
          assign in_flit[n][y][x][dir_n_lp] = '0;
          assign out_rdy[n][y][x][dir_n_lp] = 1'b1;
        end

        if (y < y_dim_lp - 1)
        begin : s_link
          assign in_v[n][y][x][dir_s_lp]    = out_v[n][y+1][x][dir_n_lp];
          assign in_flit[n][y][x][dir_s_lp] = out_flit[n][y+1][x][dir_n_lp];
          assign out_rdy[n][y][x][dir_s_lp] = in_rdy[n][y+1][x][dir_n_lp];
        end
        else
        begin : s_edge
          assign in_v[n][y][x][dir_s_lp]    = 1'b0;
          assign in_flit[n][y][x][dir_s_lp] = '0;
          assign out_rdy[n][y][x][dir_s_lp] = 1'b1;
        end
      end
    end
  end

endmodule

// File: bench/io_complex_tb.sv
`timescale 1ns/1ps

module io_complex_tb;

  import noc_pkg::*;

  // port index q = net*5 + p, p 0-3 tiles and 4 the I/O port.
  logic                  clk_i;
  logic                  rst_n_i;
  logic           [9:0]  src_v;
  flit_u          [9:0]  src_flit;
  logic           [9:0]  sink_rdy;
  logic           [9:0]  src_rdy;
  logic           [9:0]  out_v;
  flit_u          [9:0]  out_flit;

  logic  [3:0] cmd_tile_ready_and_o, cmd_tile_v_o, resp_tile_ready_and_o, resp_tile_v_o;
  flit_u [3:0] cmd_tile_flit_o, resp_tile_flit_o;
  logic        cmd_io_ready_and_o, cmd_io_v_o, resp_io_ready_and_o, resp_io_v_o;
  flit_u       cmd_io_flit_o, resp_io_flit_o;

  // test table, loaded from the data file.
  int          t_grp [64];
  int          t_net [64];
  int          t_src [64];
  int          t_dst [64];
  int          t_len [64];
  logic [31:0] t_seed [64];
  int          t_stall [64];
  int          t_port [64];
  bit          t_pend [64];
  bit          t_err [64];
  int          num_tests;
  bit          loaded;

  int cur_test [10];  // packet being received, -1 between packets.
  int body_cnt [10];
  int stall_pct [10];
  int done_cnt;
  int issued;
  int pass_cnt;
  int fail_cnt;
  int stray_cnt;

  io_complex u_dut
    (.clk_i                 (clk_i)
    ,.rst_n_i               (rst_n_i)
    ,.cmd_tile_v_i          (src_v[3:0])
    ,.cmd_tile_flit_i       (src_flit[3:0])
    ,.cmd_tile_ready_and_o  (cmd_tile_ready_and_o)
    ,.cmd_tile_v_o          (cmd_tile_v_o)
    ,.cmd_tile_flit_o       (cmd_tile_flit_o)
    ,.cmd_tile_ready_and_i  (sink_rdy[3:0])
    ,.cmd_io_v_i            (src_v[4])
    ,.cmd_io_flit_i         (src_flit[4])
    ,.cmd_io_ready_and_o    (cmd_io_ready_and_o)
    ,.cmd_io_v_o            (cmd_io_v_o)
    ,.cmd_io_flit_o         (cmd_io_flit_o)
    ,.cmd_io_ready_and_i    (sink_rdy[4])
    ,.resp_tile_v_i         (src_v[8:5])
    ,.resp_tile_flit_i      (src_flit[8:5])
    ,.resp_tile_ready_and_o (resp_tile_ready_and_o)
    ,.resp_tile_v_o         (resp_tile_v_o)
    ,.resp_tile_flit_o      (resp_tile_flit_o)
    ,.resp_tile_ready_and_i (sink_rdy[8:5])
    ,.resp_io_v_i           (src_v[9])
    ,.resp_io_flit_i        (src_flit[9])
    ,.resp_io_ready_and_o   (resp_io_ready_and_o)
    ,.resp_io_v_o           (resp_io_v_o)
    ,.resp_io_flit_o        (resp_io_flit_o)
    ,.resp_io_ready_and_i   (sink_rdy[9])
    );

  assign src_rdy  = {resp_io_ready_and_o, resp_tile_ready_and_o,
                     cmd_io_ready_and_o, cmd_tile_ready_and_o};
  assign out_v    = {resp_io_v_o, resp_tile_v_o, cmd_io_v_o, cmd_tile_v_o};
  assign out_flit = {resp_io_flit_o, resp_tile_flit_o, cmd_io_flit_o, cmd_tile_flit_o};

  always #50 clk_i = ~clk_i;

  // **********************************************************************
  // sources and sinks
  // **********************************************************************

  function automatic flit_u make_header(input int t);
    flit_u h;
    h             = '0;
    h.hdr.dest_x  = cord_x_width_lp'((t_dst[t] == num_tile_lp) ? io_x_lp : t_dst[t] % 2);
    h.hdr.dest_y  = cord_y_width_lp'((t_dst[t] == num_tile_lp) ? 0 : t_dst[t] / 2);
    h.hdr.len     = len_width_lp'(t_len[t]);
    h.hdr.src_x   = cord_x_width_lp'((t_src[t] == num_tile_lp) ? io_x_lp : t_src[t] % 2);
    h.hdr.src_y   = cord_y_width_lp'((t_src[t] == num_tile_lp) ? 0 : t_src[t] / 2);
    h.hdr.payload = t[$bits(h.hdr.payload)-1:0];  // test id keeps every header unique.
    return h;
  endfunction

  // entered 10 ns after a rising edge.
  task automatic send_packet(input int t);
    int    s;
    flit_u f;
    s = t_net[t] * 5 + t_src[t];
    for (int i = 0; i <= t_len[t]; i++)
    begin
      if (i == 0)
        f = make_header(t);
      else
        f.data = t_seed[t] + 32'(i - 1);
      src_v[s]    = 1'b1;
      src_flit[s] = f;
      do
        @(negedge clk_i);
      while (!src_rdy[s]);
      @(posedge clk_i);
      #10;
    end
    src_v[s] = 1'b0;
  endtask

  task automatic finish_test(input int t, input int q);
    cur_test[q] = -1;
    done_cnt++;
    if (t_err[t])
      fail_cnt++;
    else
      pass_cnt++;
    $display("test %0d (net %0d, src %0d, dst %0d, len %0d): %s", t, t_net[t], t_src[t],
             t_dst[t], t_len[t], t_err[t] ? "FAILED" : "ok");
  endtask

  task automatic take_flit(input int q, input flit_u f);
    int          hit;
    int          t;
    logic [31:0] expect_data;
    hit = -1;
    if (cur_test[q] < 0)
    begin
      for (int k = 0; k < num_tests; k++)
        if (hit < 0 && t_pend[k] && t_port[k] == q && make_header(k) == f)
          hit = k;
      assert (hit >= 0)
      else
      begin
        $display("MISMATCH %0t: net %0d port %0d got header %h with no packet due",
                 $time, q / 5, q % 5, f.data);
        stray_cnt++;
      end
      if (hit >= 0)
      begin
        t_pend[hit]  = 1'b0;
        cur_test[q]  = hit;
        body_cnt[q]  = 0;
        if (t_len[hit] == 0)
          finish_test(hit, q);
      end
    end
    else
    begin
      t           = cur_test[q];
      expect_data = t_seed[t] + 32'(body_cnt[q]);
      assert (f.data == expect_data)
      else
      begin
        $display("MISMATCH %0t: net %0d port %0d test %0d body %0d got %h expected %h",
                 $time, q / 5, q % 5, t, body_cnt[q], f.data, expect_data);
        t_err[t] = 1'b1;
      end
      body_cnt[q]++;
      if (body_cnt[q] == t_len[t])
        finish_test(t, q);
    end
  endtask

  // a transfer seen here completes on the next rising edge.
  always @(negedge clk_i)
  begin
    if (rst_n_i)
      for (int q = 0; q < 10; q++)
        if (out_v[q] && sink_rdy[q])
          take_flit(q, out_flit[q]);
  end

  always
  begin
    @(posedge clk_i);
    #10;
    for (int q = 0; q < 10; q++)
      sink_rdy[q] = (($urandom % 100) >= stall_pct[q]);
  end

  // **********************************************************************
  // test flow
  // **********************************************************************

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/io_complex_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open bench/io_complex_tests.txt");
      stray_cnt++;
    end
    else
    begin
      while (!$feof(fd) && num_tests < $size(t_net))
      begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%d %d %d %d %d %h %d", t_grp[num_tests],
            t_net[num_tests], t_src[num_tests], t_dst[num_tests], t_len[num_tests],
            t_seed[num_tests], t_stall[num_tests]) == 7)
        begin
          t_port[num_tests] = t_net[num_tests] * 5 + t_dst[num_tests];
          num_tests++;
        end
      end
      $fclose(fd);
      if (num_tests == 0)
      begin
        $display("no tests found in bench/io_complex_tests.txt");
        stray_cnt++;
      end
    end
  endtask

  task automatic check_reset();
    bit ok;
    ok = 1'b1;
    assert (out_v == '0 && src_rdy == '1)
    else
    begin
      $display("MISMATCH %0t: after reset v outputs %b, ready_and outputs %b",
               $time, out_v, src_rdy);
      ok = 1'b0;
    end
    if (ok)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test reset: %s", ok ? "ok" : "FAILED");
  endtask

  function automatic bit outstanding(input int q);
    bit busy;
    busy = (cur_test[q] >= 0);
    for (int k = 0; k < num_tests; k++)
      if (t_pend[k] && t_port[k] == q)
        busy = 1'b1;
    return busy;
  endfunction

  initial
  begin
    int seed;
    int first;
    int grp_end;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    src_v    = '0;
    src_flit = '0;
    sink_rdy = '1;
    for (int q = 0; q < 10; q++)
    begin
      cur_test[q]  = -1;
      stall_pct[q] = 0;
    end
    seed = $urandom(55575);
    load_tests();
    loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_reset();
    @(posedge clk_i);
    #10;
    first = 0;
    while (first < num_tests)
    begin
      grp_end = first;
      while (grp_end < num_tests && t_grp[grp_end] == t_grp[first])
        grp_end++;
      for (int k = first; k < grp_end; k++)
      begin
        t_pend[k]              = 1'b1;
        stall_pct[t_port[k]]   = t_stall[k];
      end
      issued += grp_end - first;
      for (int k = first; k < grp_end; k++)
        fork
          automatic int t = k;
          send_packet(t);
        join_none
      wait fork;
      wait (done_cnt == issued);
      @(posedge clk_i);
      #10;
      first = grp_end;
    end
    repeat (20) @(posedge clk_i);  // late or duplicated flits.
    $display("summary: %0d passed, %0d failed, %0d stray errors",
             pass_cnt, fail_cnt, stray_cnt);
    if (fail_cnt == 0 && stray_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog, 300 cycles per test.
  initial
  begin
    wait (loaded);
    repeat ((num_tests + 1) * 300) @(posedge clk_i);
    $display("timeout after %0d cycles, %0d of %0d packets done", (num_tests + 1) * 300,
             done_cnt, issued);
    for (int q = 0; q < 10; q++)
      if (outstanding(q))
        $display("  net %0d port %0d still has packets outstanding", q / 5, q % 5);
    $display("tests failed");
    $finish;
  end

endmodule

// File: io_complex.f
src/noc_pkg.sv
src/flit_fifo.sv
src/rr_arbiter.sv
src/wormhole_router.sv
src/io_complex.sv
bench/io_complex_tb.sv

// File: bench/io_complex_tests.txt
# group net src dst len seed(hex) stall(%)
# net 0 cmd, 1 resp; src and dst 0-3 are tiles, 4 is the I/O port
1 0 0 0 0 00001000 0
1 0 1 1 3 00001100 0
1 0 2 2 5 00001200 0
1 0 3 3 7 00001300 0
2 0 0 1 1 00002000 0
2 0 1 2 2 00002100 0
2 0 2 3 4 00002200 0
2 0 3 0 6 00002300 0
3 0 0 2 7 00003000 0
3 0 1 3 0 00003100 0
3 0 2 0 3 00003200 0
3 0 3 1 5 00003300 0
4 0 0 3 2 00004000 0
4 0 1 0 7 00004100 0
4 0 2 1 1 00004200 0
4 0 3 2 4 00004300 0
5 1 4 0 3 00005000 0
5 0 1 4 4 00005100 0
6 1 4 1 5 00006000 0
6 0 0 4 2 00006100 0
6 0 2 4 6 00006200 0
7 1 4 2 7 00007000 0
7 0 3 4 1 00007100 0
8 1 4 3 7 00008000 10
9 0 4 3 3 00009000 0
9 1 0 4 5 00009100 0
9 1 1 4 2 00009200 0
10 0 4 0 6 0000a000 0
10 1 2 4 4 0000a100 0
10 1 3 4 7 0000a200 0
11 1 0 3 7 0000b000 50
11 1 3 0 7 0000b100 50
12 1 1 2 7 0000c000 50
12 1 2 1 7 0000c100 50
13 1 0 1 7 0000d000 50
13 1 2 3 7 0000d100 50
14 1 1 0 7 0000e000 50
14 1 3 2 7 0000e100 50
15 0 0 0 5 0000f000 30
15 0 1 0 6 0000f100 30
15 0 2 0 7 0000f200 30
15 0 3 0 4 0000f300 30
16 1 1 3 7 00010000 50
16 1 2 3 3 00010100 50
16 1 3 3 6 00010200 50
16 1 4 3 5 00010300 50
17 0 0 1 7 00011000 20
17 0 3 1 0 00011100 20
17 0 4 1 4 00011200 20
